/* verilog/rv_pkg.sv */
`default_nettype none

package rv_pkg;

    // ========================================
    // Widths and fixed encodings
    // ========================================
    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    // ADDI x0,x0,0
    localparam logic [xlen-1:0] nop_instr   = 32'h0000_0013;
    localparam logic [xlen-1:0] ecall_instr = 32'h0000_0073;
    localparam logic [xlen-1:0] reset_pc    = 32'h0000_0000;

    // ========================================
    // Opcodes and operations
    // ========================================
    typedef enum logic [6:0] {
        op_reg    = 7'b0110011,
        op_imm    = 7'b0010011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_branch = 7'b1100011,
        op_system = 7'b1110011
    } opcode_e;

    typedef enum logic [2:0] {
        alu_add = 3'd0,
        alu_sub = 3'd1,
        alu_and = 3'd2,
        alu_or  = 3'd3,
        alu_xor = 3'd4,
        alu_slt = 3'd5
    } alu_op_e;

    // Operand source in EX
    typedef enum logic [1:0] {
        fwd_none = 2'b00,
        fwd_wb   = 2'b01,
        fwd_mem  = 2'b10
    } fwd_sel_e;

    // ========================================
    // Control bundle and pipeline registers
    // ========================================
    typedef struct packed {
        logic    regwrite;
        logic    alusrc;
        logic    memread;
        logic    memwrite;
        logic    memtoreg;
        logic    branch;
        alu_op_e alu_op;
    } ctrl_t;

    typedef struct packed {
        ctrl_t                 ctrl;
        logic [xlen-1:0]       pc;
        logic [xlen-1:0]       rs1_data;
        logic [xlen-1:0]       rs2_data;
        logic [xlen-1:0]       imm;
        logic [reg_addr_w-1:0] rs1;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rd;
        // Set for BNE, clear for BEQ
        logic                  branch_ne;
    } id_ex_t;

    typedef struct packed {
        logic                  regwrite;
        logic                  memread;
        logic                  memwrite;
        logic                  memtoreg;
        logic [xlen-1:0]       alu_result;
        logic [xlen-1:0]       store_data;
        logic [reg_addr_w-1:0] rd;
    } ex_mem_t;

    typedef struct packed {
        logic                  regwrite;
        logic                  memtoreg;
        logic [xlen-1:0]       alu_result;
        logic [xlen-1:0]       load_data;
        logic [reg_addr_w-1:0] rd;
    } mem_wb_t;

endpackage

`default_nettype wire

/* verilog/rv_fetch.sv */
`timescale 1ns/1ns
`default_nettype none

module rv_fetch (
    input  wire logic                    clock,
    input  wire logic                    reset,
    input  wire logic                    stall,
    input  wire logic                    flush,
    input  wire logic                    branch_taken,
    input  wire logic [rv_pkg::xlen-1:0] branch_target,
    input  wire logic [rv_pkg::xlen-1:0] imem_rdata,
    output logic      [rv_pkg::xlen-1:0] imem_addr,
    output logic      [rv_pkg::xlen-1:0] pc_id,
    output logic      [rv_pkg::xlen-1:0] instr_id,
    output logic                         halted
);

    logic [rv_pkg::xlen-1:0] pc;
    logic                    halt_now;
    logic                    hold;

    // ECALL that really leaves ID this cycle
    assign halt_now = (instr_id == rv_pkg::ecall_instr) && !flush && !stall;
    // Keep the ECALL parked in IF/ID from the halting edge on
    assign hold      = stall || halted || halt_now;
    assign imem_addr = pc;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            pc <= rv_pkg::reset_pc;
        end else if (branch_taken) begin
            pc <= branch_target;
        end else if (!hold) begin
            pc <= pc + 32'd4;
        end
    end

    // ========================================
    // IF/ID register
    // ========================================
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            instr_id <= rv_pkg::nop_instr;
            pc_id    <= rv_pkg::reset_pc;
        end else if (flush) begin
            instr_id <= rv_pkg::nop_instr;
        end else if (!hold) begin
            instr_id <= imem_rdata;
            pc_id    <= pc;
        end
    end

    // Sticky until reset
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            halted <= 1'b0;
        end else if (halt_now) begin
            halted <= 1'b1;
        end
    end

endmodule

`default_nettype wire

/* verilog/rv_decode.sv */
`timescale 1ns/1ns
`default_nettype none

module rv_decode (
    input  wire logic [rv_pkg::xlen-1:0]       instr,
    output rv_pkg::ctrl_t                      ctrl,
    output logic      [rv_pkg::xlen-1:0]       imm,
    output logic      [rv_pkg::reg_addr_w-1:0] rs1,
    output logic      [rv_pkg::reg_addr_w-1:0] rs2,
    output logic      [rv_pkg::reg_addr_w-1:0] rd,
    output logic                               branch_ne
);

    rv_pkg::opcode_e opcode;
    logic [2:0]      funct3;
    logic            funct7_5;
    rv_pkg::alu_op_e arith_op;
    logic            arith_ok;

    assign opcode    = rv_pkg::opcode_e'(instr[6:0]);
    assign funct3    = instr[14:12];
    assign funct7_5  = instr[30];
    assign rd        = instr[11:7];
    assign rs1       = instr[19:15];
    assign rs2       = instr[24:20];
    assign branch_ne = instr[12];

    // Shared funct3 map for register and immediate forms
    always_comb begin
        arith_ok = 1'b1;
        case (funct3)
            3'b000:  arith_op = rv_pkg::alu_add;
            3'b111:  arith_op = rv_pkg::alu_and;
            3'b110:  arith_op = rv_pkg::alu_or;
            3'b100:  arith_op = rv_pkg::alu_xor;
            3'b010:  arith_op = rv_pkg::alu_slt;
            default: begin
                // shifts and unsigned compare are not in the subset
                arith_op = rv_pkg::alu_add;
                arith_ok = 1'b0;
            end
        endcase
    end

    always_comb begin
        ctrl = '0;
        case (opcode)
            rv_pkg::op_reg: begin
                ctrl.regwrite = arith_ok;
                ctrl.alu_op   = (funct3 == 3'b000 && funct7_5) ? rv_pkg::alu_sub : arith_op;
            end
            rv_pkg::op_imm: begin
                ctrl.regwrite = arith_ok;
                ctrl.alusrc   = 1'b1;
                ctrl.alu_op   = arith_op;
            end
            rv_pkg::op_load: begin
                ctrl.regwrite = 1'b1;
                ctrl.alusrc   = 1'b1;
                ctrl.memread  = 1'b1;
                ctrl.memtoreg = 1'b1;
            end
            rv_pkg::op_store: begin
                ctrl.alusrc   = 1'b1;
                ctrl.memwrite = 1'b1;
            end
            rv_pkg::op_branch: begin
                ctrl.branch = 1'b1;
                ctrl.alu_op = rv_pkg::alu_sub;
            end
            default: ctrl = '0;
        endcase
    end

    // ========================================
    // Immediate generation
    // ========================================
    always_comb begin
        case (opcode)
            rv_pkg::op_store:
                imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            rv_pkg::op_branch:
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            default:
                imm = {{20{instr[31]}}, instr[31:20]};
        endcase
    end

endmodule

`default_nettype wire

/* verilog/rv_regfile.sv */
`timescale 1ns/1ns
`default_nettype none

module rv_regfile (
    input  wire logic                               clock,
    input  wire logic                               reset,
    input  wire logic      [rv_pkg::reg_addr_w-1:0] rs1,
    input  wire logic      [rv_pkg::reg_addr_w-1:0] rs2,
    input  wire logic                               we,
    input  wire logic      [rv_pkg::reg_addr_w-1:0] rd,
    input  wire logic      [rv_pkg::xlen-1:0]       wdata,
    output logic           [rv_pkg::xlen-1:0]       rdata1,
    output logic           [rv_pkg::xlen-1:0]       rdata2
);

    // x0 has no storage
    logic [rv_pkg::xlen-1:0] regs [1:31];
    logic                    write_ok;

    assign write_ok = we && (rd != '0);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (write_ok) begin
            regs[rd] <= wdata;
        end
    end

    // Write-first bypass
    assign rdata1 = (rs1 == '0) ? '0 : (write_ok && rd == rs1) ? wdata : regs[rs1];
    assign rdata2 = (rs2 == '0) ? '0 : (write_ok && rd == rs2) ? wdata : regs[rs2];

endmodule

`default_nettype wire

/* verilog/rv_hazard.sv */
`timescale 1ns/1ns
`default_nettype none

module rv_hazard (
    input  wire logic [rv_pkg::reg_addr_w-1:0] rs1_id,
    input  wire logic [rv_pkg::reg_addr_w-1:0] rs2_id,
    input  wire logic [rv_pkg::reg_addr_w-1:0] rd_ex,
    input  wire logic                          memread_ex,
    input  wire logic [rv_pkg::reg_addr_w-1:0] rs1_ex,
    input  wire logic [rv_pkg::reg_addr_w-1:0] rs2_ex,
    input  wire logic [rv_pkg::reg_addr_w-1:0] rd_mem,
    input  wire logic                          regwrite_mem,
    input  wire logic [rv_pkg::reg_addr_w-1:0] rd_wb,
    input  wire logic                          regwrite_wb,
    input  wire logic                          branch_taken,
    output logic                               stall,
    output logic                               flush_if_id,
    output logic                               flush_id_ex,
    output rv_pkg::fwd_sel_e                   fwd_a,
    output rv_pkg::fwd_sel_e                   fwd_b
);

    logic load_use;

    // EX/MEM wins over MEM/WB, x0 never forwarded
    function automatic rv_pkg::fwd_sel_e pick_src(input logic [rv_pkg::reg_addr_w-1:0] rs);
        if (regwrite_mem && rd_mem != '0 && rd_mem == rs) begin
            return rv_pkg::fwd_mem;
        end else if (regwrite_wb && rd_wb != '0 && rd_wb == rs) begin
            return rv_pkg::fwd_wb;
        end
        return rv_pkg::fwd_none;
    endfunction

    assign load_use = memread_ex && (rd_ex != '0) && (rd_ex == rs1_id || rd_ex == rs2_id);

    // The younger load-use pair is thrown away anyway on a taken branch
    assign stall       = load_use && !branch_taken;
    assign flush_if_id = branch_taken;
    assign flush_id_ex = branch_taken;

    always_comb begin
        fwd_a = pick_src(rs1_ex);
        fwd_b = pick_src(rs2_ex);
    end

endmodule

`default_nettype wire

/* verilog/rv_execute.sv */
`timescale 1ns/1ns
`default_nettype none

module rv_execute (
    input  rv_pkg::id_ex_t                     id_ex,
    input  rv_pkg::fwd_sel_e                   fwd_a,
    input  rv_pkg::fwd_sel_e                   fwd_b,
    input  wire logic      [rv_pkg::xlen-1:0]  mem_result,
    input  wire logic      [rv_pkg::xlen-1:0]  wb_data,
    output logic           [rv_pkg::xlen-1:0]  alu_result,
    output logic           [rv_pkg::xlen-1:0]  store_data,
    output logic           [rv_pkg::xlen-1:0]  branch_target,
    output logic                               branch_taken
);

    logic [rv_pkg::xlen-1:0] op_a;
    logic [rv_pkg::xlen-1:0] op_b_reg;
    logic [rv_pkg::xlen-1:0] op_b;
    logic                    equal;

    function automatic logic [rv_pkg::xlen-1:0] fwd_mux(
        input rv_pkg::fwd_sel_e        sel,
        input logic [rv_pkg::xlen-1:0] reg_data
    );
        case (sel)
            rv_pkg::fwd_mem: return mem_result;
            rv_pkg::fwd_wb:  return wb_data;
            default:         return reg_data;
        endcase
    endfunction

    // ========================================
    // Operand selection
    // ========================================
    always_comb begin
        op_a     = fwd_mux(fwd_a, id_ex.rs1_data);
        op_b_reg = fwd_mux(fwd_b, id_ex.rs2_data);
    end

    assign op_b       = id_ex.ctrl.alusrc ? id_ex.imm : op_b_reg;
    assign store_data = op_b_reg;

    always_comb begin
        case (id_ex.ctrl.alu_op)
            rv_pkg::alu_sub: alu_result = op_a - op_b;
            rv_pkg::alu_and: alu_result = op_a & op_b;
            rv_pkg::alu_or:  alu_result = op_a | op_b;
            rv_pkg::alu_xor: alu_result = op_a ^ op_b;
            rv_pkg::alu_slt: alu_result = {31'd0, $signed(op_a) < $signed(op_b)};
            default:         alu_result = op_a + op_b;
        endcase
    end

    // ========================================
    // Branch resolution
    // ========================================
    assign equal         = (op_a == op_b_reg);
    assign branch_taken  = id_ex.ctrl.branch && (equal ^ id_ex.branch_ne);
    assign branch_target = id_ex.pc + id_ex.imm;

endmodule

`default_nettype wire

/* verilog/rv_core.sv */
`timescale 1ns/1ns
`default_nettype none

module rv_core (
    input  wire logic                    clock,
    input  wire logic                    reset,
    input  wire logic [rv_pkg::xlen-1:0] imem_rdata,
    input  wire logic [rv_pkg::xlen-1:0] dmem_rdata,
    output logic      [rv_pkg::xlen-1:0] imem_addr,
    output logic      [rv_pkg::xlen-1:0] dmem_addr,
    output logic      [rv_pkg::xlen-1:0] dmem_wdata,
    output logic                         dmem_valid,
    output logic                         dmem_we,
    output logic                         halted
);

    logic [rv_pkg::xlen-1:0]       pc_id, instr_id, imm_id;
    logic [rv_pkg::xlen-1:0]       rdata1_id, rdata2_id;
    logic [rv_pkg::reg_addr_w-1:0] rs1_id, rs2_id, rd_id;
    logic                          branch_ne_id;
    rv_pkg::ctrl_t                 ctrl_id;

    logic                          stall, flush_if_id, flush_id_ex;
    rv_pkg::fwd_sel_e              fwd_a, fwd_b;

    logic [rv_pkg::xlen-1:0]       alu_result_ex, store_data_ex;
    logic [rv_pkg::xlen-1:0]       branch_target;
    logic                          branch_taken;
    logic [rv_pkg::xlen-1:0]       wb_data;

    rv_pkg::id_ex_t                id_ex_d, id_ex_q;
    rv_pkg::ex_mem_t               ex_mem_d, ex_mem_q;
    rv_pkg::mem_wb_t               mem_wb_d, mem_wb_q;

    // ========================================
    // IF and ID
    // ========================================
    rv_fetch i_fetch (
        .clock, .reset, .stall, .flush(flush_if_id), .branch_taken, .branch_target,
        .imem_rdata, .imem_addr, .pc_id, .instr_id, .halted
    );

    rv_decode i_decode (
        .instr(instr_id), .ctrl(ctrl_id), .imm(imm_id),
        .rs1(rs1_id), .rs2(rs2_id), .rd(rd_id), .branch_ne(branch_ne_id)
    );

    rv_regfile i_regfile (
        .clock, .reset, .rs1(rs1_id), .rs2(rs2_id),
        .we(mem_wb_q.regwrite), .rd(mem_wb_q.rd), .wdata(wb_data),
        .rdata1(rdata1_id), .rdata2(rdata2_id)
    );

    rv_hazard i_hazard (
        .rs1_id, .rs2_id, .rd_ex(id_ex_q.rd), .memread_ex(id_ex_q.ctrl.memread),
        .rs1_ex(id_ex_q.rs1), .rs2_ex(id_ex_q.rs2),
        .rd_mem(ex_mem_q.rd), .regwrite_mem(ex_mem_q.regwrite),
        .rd_wb(mem_wb_q.rd), .regwrite_wb(mem_wb_q.regwrite),
        .branch_taken, .stall, .flush_if_id, .flush_id_ex, .fwd_a, .fwd_b
    );

    // Bubble on stall or flush
    assign id_ex_d = '{
        ctrl:      (stall || flush_id_ex) ? '0 : ctrl_id,
        pc:        pc_id,
        rs1_data:  rdata1_id,
        rs2_data:  rdata2_id,
        imm:       imm_id,
        rs1:       rs1_id,
        rs2:       rs2_id,
        rd:        rd_id,
        branch_ne: branch_ne_id
    };

    // ========================================
    // EX
    // ========================================
    rv_execute i_execute (
        .id_ex(id_ex_q), .fwd_a, .fwd_b, .mem_result(ex_mem_q.alu_result), .wb_data,
        .alu_result(alu_result_ex), .store_data(store_data_ex), .branch_target, .branch_taken
    );

    assign ex_mem_d = '{
        regwrite:   id_ex_q.ctrl.regwrite,
        memread:    id_ex_q.ctrl.memread,
        memwrite:   id_ex_q.ctrl.memwrite,
        memtoreg:   id_ex_q.ctrl.memtoreg,
        alu_result: alu_result_ex,
        store_data: store_data_ex,
        rd:         id_ex_q.rd
    };

    // ========================================
    // MEM and WB
    // ========================================
    assign dmem_addr  = ex_mem_q.alu_result;
    assign dmem_wdata = ex_mem_q.store_data;
    assign dmem_valid = ex_mem_q.memread || ex_mem_q.memwrite;
    assign dmem_we    = ex_mem_q.memwrite;

    assign mem_wb_d = '{
        regwrite:   ex_mem_q.regwrite,
        memtoreg:   ex_mem_q.memtoreg,
        alu_result: ex_mem_q.alu_result,
        load_data:  dmem_rdata,
        rd:         ex_mem_q.rd
    };

    assign wb_data = mem_wb_q.memtoreg ? mem_wb_q.load_data : mem_wb_q.alu_result;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            id_ex_q  <= '0;
            ex_mem_q <= '0;
            mem_wb_q <= '0;
        end else begin
            id_ex_q  <= id_ex_d;
            ex_mem_q <= ex_mem_d;
            mem_wb_q <= mem_wb_d;
        end
    end

endmodule

`default_nettype wire

/* testbench/rv_core_assert.sv */
`timescale 1ns/1ns
`default_nettype none

module rv_core_assert (
    input wire logic                    clock,
    input wire logic                    reset,
    input wire logic [rv_pkg::xlen-1:0] imem_addr,
    input wire logic                    dmem_valid,
    input wire logic                    dmem_we,
    input wire logic                    halted
);

    // Read by the testbench at the end of each test
    int failures = 0;

    // A store is always a data access
    we_implies_valid: assert property (@(posedge clock) disable iff (reset)
        dmem_we |-> dmem_valid)
        else begin
            $error("dmem_we high without dmem_valid");
            failures++;
        end

    halted_sticky: assert property (@(posedge clock) disable iff (reset)
        halted |=> halted)
        else begin
            $error("halted fell without reset");
            failures++;
        end

    // Fetch is frozen once halted
    pc_frozen: assert property (@(posedge clock) disable iff (reset)
        halted |=> $stable(imem_addr))
        else begin
            $error("imem_addr moved while halted");
            failures++;
        end

    quiet_after_reset: assert property (@(posedge clock)
        $fell(reset) |-> !dmem_valid)
        else begin
            $error("dmem_valid high in the first cycle after reset");
            failures++;
        end

endmodule

bind rv_core rv_core_assert i_assert (
    .clock, .reset, .imem_addr, .dmem_valid, .dmem_we, .halted
);

`default_nettype wire

/* testbench/tb_rv_core.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_rv_core;

    localparam int mem_words = 256;

    logic        clock = 1'b0;
    logic        reset;
    logic [31:0] imem_rdata;
    logic [31:0] dmem_rdata;
    logic [31:0] imem_addr;
    logic [31:0] dmem_addr;
    logic [31:0] dmem_wdata;
    logic        dmem_valid;
    logic        dmem_we;
    logic        halted;

    logic [31:0] imem     [0:mem_words-1];
    logic [31:0] dmem     [0:mem_words-1];
    logic [31:0] init_mem [0:mem_words-1];
    logic [31:0] ref_mem  [0:mem_words-1];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];

    integer seed = 32'h0b6f3948;
    int     prog_len;
    int     store_idx;
    int     exp_loads;
    int     load_count;
    int     assert_seen;
    int     errors;
    int     tests_run;
    int     tests_failed;
    int     cycle_count;
    // Enough for the first reset, each test adds its own budget
    int     cycle_limit = 20;

    always #2 clock = ~clock;

    rv_core i_dut (
        .clock, .reset, .imem_rdata, .dmem_rdata, .imem_addr,
        .dmem_addr, .dmem_wdata, .dmem_valid, .dmem_we, .halted
    );

    // ========================================
    // Memories
    // ========================================
    assign imem_rdata = imem[imem_addr[9:2]];
    assign dmem_rdata = dmem[dmem_addr[9:2]];

    always @(posedge clock) begin
        if (dmem_we) begin
            dmem[dmem_addr[9:2]] <= dmem_wdata;
        end
    end

    // ========================================
    // Instruction encoding
    // ========================================
    function automatic logic [31:0] rtype(input int funct7, input int funct3, input int rd,
                                          input int rs1, input int rs2);
        return {funct7[6:0], rs2[4:0], rs1[4:0], funct3[2:0], rd[4:0], 7'b0110011};
    endfunction

    function automatic logic [31:0] itype(input int opcode, input int funct3, input int rd,
                                          input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], funct3[2:0], rd[4:0], opcode[6:0]};
    endfunction

    function automatic logic [31:0] stype(input int rs2, input int rs1, input int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] btype(input int funct3, input int rs1, input int rs2,
                                          input int offset);
        return {offset[12], offset[10:5], rs2[4:0], rs1[4:0], funct3[2:0],
                offset[4:1], offset[11], 7'b1100011};
    endfunction

    task automatic emit(input logic [31:0] word);
        imem[prog_len] = word;
        prog_len++;
    endtask

    task automatic addi(input int rd, input int rs1, input int imm);
        emit(itype(7'h13, 0, rd, rs1, imm));
    endtask

    task automatic lw(input int rd, input int rs1, input int imm);
        emit(itype(7'h03, 2, rd, rs1, imm));
    endtask

    task automatic sw(input int rs2, input int rs1, input int imm);
        emit(stype(rs2, rs1, imm));
    endtask

    // Unused words hold ECALL so a runaway PC still halts
    task automatic start_program();
        logic [31:0] byte_addr;
        prog_len = 0;
        for (int i = 0; i < mem_words; i++) begin
            byte_addr   = i * 4;
            imem[i]     = 32'h0000_0073;
            init_mem[i] = (byte_addr + 32'h10) * 32'h9e37_79b9;
        end
    endtask

    // ========================================
    // Instruction-set model
    // ========================================
    function automatic int run_reference();
        logic [31:0] regs [0:31];
        logic [31:0] pc;
        logic [31:0] instr;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [31:0] addr;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [31:0] imm_b;
        logic [4:0]  rd;
        int          steps;
        bit          running;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        pc        = '0;
        steps     = 0;
        running   = 1'b1;
        exp_loads = 0;
        exp_addr.delete();
        exp_data.delete();
        while (running && steps < 4096) begin
            instr = imem[pc[9:2]];
            rd    = instr[11:7];
            a     = regs[instr[19:15]];
            b     = regs[instr[24:20]];
            imm_i = {{20{instr[31]}}, instr[31:20]};
            imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            steps++;
            case (instr[6:0])
                7'h33, 7'h13: begin
                    if (instr[6:0] == 7'h13) begin
                        b = imm_i;
                    end
                    case (instr[14:12])
                        3'b000:  res = (instr[6:0] == 7'h33 && instr[30]) ? a - b : a + b;
                        3'b111:  res = a & b;
                        3'b110:  res = a | b;
                        3'b100:  res = a ^ b;
                        default: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    endcase
                    if (rd != 0) begin
                        regs[rd] = res;
                    end
                    pc = pc + 4;
                end
                7'h03: begin
                    addr = a + imm_i;
                    if (rd != 0) begin
                        regs[rd] = ref_mem[addr[9:2]];
                    end
                    exp_loads++;
                    pc = pc + 4;
                end
                7'h23: begin
                    addr = a + imm_s;
                    ref_mem[addr[9:2]] = b;
                    exp_addr.push_back(addr);
                    exp_data.push_back(b);
                    pc = pc + 4;
                end
                // BEQ when funct3 bit 0 is clear, BNE when set
                7'h63:   pc = ((a == b) != instr[12]) ? pc + imm_b : pc + 4;
                7'h73:   running = 1'b0;
                default: pc = pc + 4;
            endcase
        end
        return steps;
    endfunction

    // ========================================
    // Checking
    // ========================================
    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, what, got, expected);
            errors++;
        end
    endtask

    // Stores are compared in program order
    always @(negedge clock) begin
        if (!reset && dmem_we) begin
            if (store_idx < exp_addr.size()) begin
                check_value("store address", dmem_addr, exp_addr[store_idx]);
                check_value("store data", dmem_wdata, exp_data[store_idx]);
            end else begin
                $display("Unexpected store of %h to %h after all expected stores at %0t ns",
                         dmem_wdata, dmem_addr, $time);
                errors++;
            end
            store_idx++;
        end
        // Each load shows up as one valid cycle without a write
        if (!reset && dmem_valid && !dmem_we) begin
            load_count++;
        end
    end

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("Timeout: the core did not halt within %0d cycles", cycle_limit);
            $display("=== FAIL ===");
            $finish;
        end
    end

    task automatic load_state();
        int steps;
        for (int i = 0; i < mem_words; i++) begin
            dmem[i]    = init_mem[i];
            ref_mem[i] = init_mem[i];
        end
        steps       = run_reference();
        store_idx   = 0;
        load_count  = 0;
        cycle_limit = cycle_limit + steps * 4 + 40;
    endtask

    task automatic apply_reset();
        @(posedge clock);
        #1;
        reset = 1'b1;
        load_state();
        repeat (10) begin
            @(negedge clock);
            check_value("dmem_valid during reset", 32'(dmem_valid), 0);
            check_value("halted during reset", 32'(halted), 0);
            check_value("imem_addr during reset", imem_addr, 0);
        end
        @(posedge clock);
        #1;
        reset = 1'b0;
        @(negedge clock);
        check_value("first fetch address", imem_addr, 0);
    endtask

    task automatic run_test(input string name);
        int errors_before;
        errors_before = errors;
        apply_reset();
        while (!halted) begin
            @(negedge clock);
        end
        // Older instructions drain within three cycles
        repeat (4) @(negedge clock);
        for (int i = 0; i < mem_words; i++) begin
            check_value($sformatf("dmem word %0d", i), dmem[i], ref_mem[i]);
        end
        check_value("number of stores", store_idx, exp_addr.size());
        check_value("number of loads", load_count, exp_loads);
        // Failures of the bound assertions count as errors
        errors      = errors + i_dut.i_assert.failures - assert_seen;
        assert_seen = i_dut.i_assert.failures;
        tests_run++;
        if (errors == errors_before) begin
            $display("Test %-10s passed", name);
        end else begin
            tests_failed++;
            $display("Test %-10s failed with %0d errors", name, errors - errors_before);
        end
    endtask

    // ========================================
    // Programs
    // ========================================
    task automatic arith_program();
        int f3 [5] = '{0, 7, 6, 4, 2};
        int slot;
        start_program();
        slot = 0;
        addi(10, 0, 'h200);
        for (int k = 0; k < 4; k++) begin
            init_mem[64 + 2 * k] = $random(seed);
            init_mem[65 + 2 * k] = $random(seed);
            lw(1, 0, 256 + 8 * k);
            lw(2, 0, 260 + 8 * k);
            for (int j = 0; j < 5; j++) begin
                emit(rtype(0, f3[j], 3, 1, 2));
                sw(3, 10, slot * 4);
                emit(itype(7'h13, f3[j], 4, 1, $random(seed)));
                sw(4, 10, slot * 4 + 4);
                slot += 2;
            end
            emit(rtype(7'h20, 0, 3, 1, 2));
            sw(3, 10, slot * 4);
            slot++;
        end
    endtask

    task automatic forwarding_program();
        start_program();
        addi(1, 0, 5);
        addi(2, 1, 7);
        emit(rtype(0, 0, 3, 1, 2));
        emit(rtype(7'h20, 0, 4, 3, 1));
        sw(4, 0, 'h300);
        emit(rtype(0, 4, 5, 4, 2));
        emit(rtype(0, 6, 6, 5, 3));
        sw(6, 0, 'h304);
        emit(rtype(0, 0, 7, 6, 6));
        addi(7, 7, 1);
        sw(7, 0, 'h308);
        // A write to x0 must not leak into the next reader
        addi(0, 2, 9);
        emit(rtype(0, 0, 9, 0, 2));
        sw(9, 0, 'h30c);
        addi(11, 0, 'h310);
        sw(3, 11, 0);
        emit(rtype(0, 2, 12, 2, 1));
        sw(12, 11, 4);
    endtask

    task automatic load_use_program();
        start_program();
        addi(5, 0, 123);
        lw(1, 0, 'h40);
        emit(rtype(0, 0, 2, 1, 5));
        sw(2, 0, 'h320);
        lw(3, 0, 'h44);
        emit(rtype(7'h20, 0, 4, 5, 3));
        sw(4, 0, 'h324);
        lw(6, 0, 'h48);
        sw(6, 0, 'h328);
    endtask

    task automatic branch_program();
        start_program();
        addi(1, 0, 5);
        addi(2, 0, 'h380);
        sw(1, 2, 0);
        addi(2, 2, 4);
        addi(1, 1, -1);
        emit(btype(1, 1, 0, -12));
        sw(2, 0, 'h3e0);
        addi(3, 0, 7);
        emit(btype(0, 0, 0, 12));
        // Skipped by the BEQ above
        sw(3, 0, 'h3f0);
        sw(3, 0, 'h3f4);
        sw(1, 0, 'h3f8);
        emit(btype(0, 3, 0, 8));
        sw(3, 0, 'h3fc);
    endtask

    task automatic halt_program();
        start_program();
        addi(1, 0, 'h55);
        addi(2, 1, 'h11);
        sw(1, 0, 'h3c0);
        sw(2, 0, 'h3c4);
        emit(32'h0000_0073);
        sw(1, 0, 'h3c8);
        sw(2, 0, 'h3cc);
        addi(3, 0, 1);
    endtask

    // ========================================
    // Test sequence
    // ========================================
    initial begin
        reset        = 1'b1;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        cycle_count  = 0;
        store_idx    = 0;
        exp_loads    = 0;
        load_count   = 0;
        assert_seen  = 0;
        start_program();
        for (int i = 0; i < mem_words; i++) begin
            dmem[i] = init_mem[i];
        end

        arith_program();
        run_test("arith");
        forwarding_program();
        run_test("forwarding");
        load_use_program();
        run_test("load_use");
        branch_program();
        run_test("branch");
        halt_program();
        run_test("halt");

        // Reset lands in the middle of the branch loop
        branch_program();
        apply_reset();
        repeat (12) @(posedge clock);
        run_test("reset");

        $display("%0d tests run, %0d passed, %0d failed, %0d errors",
                 tests_run, tests_run - tests_failed, tests_failed, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
verilog/rv_pkg.sv
verilog/rv_fetch.sv
verilog/rv_decode.sv
verilog/rv_regfile.sv
verilog/rv_hazard.sv
verilog/rv_execute.sv
verilog/rv_core.sv
testbench/rv_core_assert.sv
testbench/tb_rv_core.sv

/* Bender.yml */
package:
  name: rv_core

sources:
  - verilog/rv_pkg.sv
  - verilog/rv_fetch.sv
  - verilog/rv_decode.sv
  - verilog/rv_regfile.sv
  - verilog/rv_hazard.sv
  - verilog/rv_execute.sv
  - verilog/rv_core.sv
  - target: test
    files:
      - testbench/rv_core_assert.sv
      - testbench/tb_rv_core.sv
